/* decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// datapath and pc width
`define DATA_W 32

// register index width and count
`define REG_ADDR_W 5
`define REG_COUNT 32

// jal destination
`define LINK_REG 31

// bytes per instruction
`define PC_STEP 4

// instruction field positions
`define OP_MSB 31
`define OP_LSB 26
`define RS_MSB 25
`define RS_LSB 21
`define RT_MSB 20
`define RT_LSB 16

`endif

/* decode_pkg.sv */
`include "decode_settings.svh"

package decode_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_SA, SRC1_PC} src1_sel_e;
    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_ZIMM, SRC2_EIGHT} src2_sel_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,  // fetch address error
        EXC_SYS  = 5'd8,
        EXC_RI   = 5'd10
    } excode_e;

    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR} br_kind_e;

    typedef struct packed {
        logic                ex;
        excode_e             excode;
        logic [`DATA_W-1:0]  inst;
        logic [`DATA_W-1:0]  pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } ws_to_rf_t;

    // one forwarding source from execute or memory
    typedef struct packed {
        logic                   gr_we;
        logic                   is_load;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`DATA_W-1:0]     result;
    } fwd_t;

    typedef struct packed {
        alu_op_e                alu_op;
        src1_sel_e              src1_sel;
        src2_sel_e              src2_sel;
        logic                   gr_we;
        logic                   mem_we;
        logic                   is_load;
        logic [`REG_ADDR_W-1:0] dest;
        logic [15:0]            imm;
        logic                   uses_rs;
        logic                   uses_rt;
        br_kind_e               br_kind;
        logic                   ex;
        excode_e                excode;
    } dec_ctrl_t;

    typedef struct packed {
        logic                   ex;
        excode_e                excode;
        alu_op_e                alu_op;
        src1_sel_e              src1_sel;
        src2_sel_e              src2_sel;
        logic                   gr_we;
        logic                   mem_we;
        logic                   is_load;
        logic [`REG_ADDR_W-1:0] dest;
        logic [15:0]            imm;
        logic [`DATA_W-1:0]     rs_value;
        logic [`DATA_W-1:0]     rt_value;
        logic [`DATA_W-1:0]     pc;
    } ds_to_es_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } br_bus_t;

endpackage

/* id_pipe_ctrl.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module id_pipe_ctrl import decode_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_valid,
    input  fs_to_ds_t              fs_bus,
    input  logic                   es_allowin,
    input  fwd_t                   es_fwd,
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    input  logic                   uses_rs,
    input  logic                   uses_rt,
    output logic                   ds_allowin,
    output logic                   ds_valid_out,
    output logic                   go,
    output fs_to_ds_t              inst_reg
);

    logic ds_valid;
    logic es_load_hit;  // load in execute writes a register we read

    assign es_load_hit = es_fwd.gr_we && es_fwd.is_load && (es_fwd.dest != '0) &&
                         ((uses_rs && es_fwd.dest == rs_addr) ||
                          (uses_rt && es_fwd.dest == rt_addr));

    assign go           = !es_load_hit;
    assign ds_allowin   = !ds_valid || (go && es_allowin);
    assign ds_valid_out = ds_valid && go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;  // bubble when fetch has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            inst_reg <= fs_bus;
        end
    end

    // output valid only for an instruction that really entered the stage
    a_valid_from_accept: assert property (@(posedge clk) disable iff (reset)
        ds_valid_out |-> $past(ds_valid) || $past(fs_valid && ds_allowin));

    // execute not ready, so the bundle must not move
    a_hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        ds_valid_out && !es_allowin |=> ds_valid && $stable(inst_reg));

    // nothing entered at the last edge so the stage is empty
    a_empty_allows: assert property (@(posedge clk) disable iff (reset)
        ds_allowin && !fs_valid |=> ds_allowin);

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module inst_decoder import decode_pkg::*; (
    input  fs_to_ds_t inst_reg,
    output dec_ctrl_t ctrl
);

    logic [5:0]             op;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             sa;
    logic [5:0]             funct;
    logic                   legal;
    logic                   is_syscall;

    assign op    = inst_reg.inst[`OP_MSB:`OP_LSB];
    assign rs    = inst_reg.inst[`RS_MSB:`RS_LSB];
    assign rt    = inst_reg.inst[`RT_MSB:`RT_LSB];
    assign rd    = inst_reg.inst[15:11];
    assign sa    = inst_reg.inst[10:6];
    assign funct = inst_reg.inst[5:0];

    always_comb begin
        ctrl       = '0;  // add, rs/rt operands, no writes
        ctrl.dest  = rd;
        ctrl.imm   = inst_reg.inst[15:0];
        legal      = 1'b1;
        is_syscall = 1'b0;

        case (op)
            OP_SPECIAL: begin
                ctrl.gr_we   = 1'b1;
                ctrl.uses_rs = 1'b1;
                ctrl.uses_rt = 1'b1;
                legal        = (sa == '0);  // three-register forms
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLL: begin
                        ctrl.alu_op   = ALU_SLL;
                        ctrl.src1_sel = SRC1_SA;
                        ctrl.uses_rs  = 1'b0;
                        legal         = (rs == '0);
                    end
                    FN_SRL: begin
                        ctrl.alu_op   = ALU_SRL;
                        ctrl.src1_sel = SRC1_SA;
                        ctrl.uses_rs  = 1'b0;
                        legal         = (rs == '0);
                    end
                    FN_JR: begin
                        ctrl.gr_we   = 1'b0;
                        ctrl.uses_rt = 1'b0;
                        ctrl.br_kind = BR_JR;
                        legal        = (rt == '0) && (rd == '0) && (sa == '0);
                    end
                    FN_SYSCALL: begin
                        ctrl.gr_we   = 1'b0;
                        ctrl.uses_rs = 1'b0;
                        ctrl.uses_rt = 1'b0;
                        is_syscall   = 1'b1;
                        legal        = 1'b1;  // code field is free
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LW: begin
                ctrl.gr_we    = 1'b1;
                ctrl.uses_rs  = 1'b1;
                ctrl.dest     = rt;
                ctrl.src2_sel = (op == OP_LW || op == OP_ADDIU) ? SRC2_SIMM : SRC2_ZIMM;
                ctrl.is_load  = (op == OP_LW);
                if (op == OP_ANDI) ctrl.alu_op = ALU_AND;
                if (op == OP_ORI) ctrl.alu_op = ALU_OR;
            end
            OP_LUI: begin
                ctrl.alu_op   = ALU_LUI;
                ctrl.src2_sel = SRC2_SIMM;  // alu shifts imm up by 16
                ctrl.gr_we    = 1'b1;
                ctrl.dest     = rt;
                legal         = (rs == '0);
            end
            OP_SW: begin
                ctrl.src2_sel = SRC2_SIMM;
                ctrl.mem_we   = 1'b1;
                ctrl.uses_rs  = 1'b1;
                ctrl.uses_rt  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.br_kind = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
                ctrl.uses_rs = 1'b1;
                ctrl.uses_rt = 1'b1;
            end
            OP_J: ctrl.br_kind = BR_J;
            OP_JAL: begin
                ctrl.br_kind  = BR_JAL;
                ctrl.src1_sel = SRC1_PC;  // link value pc + 8
                ctrl.src2_sel = SRC2_EIGHT;
                ctrl.gr_we    = 1'b1;
                ctrl.dest     = `REG_ADDR_W'(`LINK_REG);
            end
            default: legal = 1'b0;
        endcase

        // fetch fault first, then syscall, then reserved instruction
        if (inst_reg.ex) begin
            ctrl.ex     = 1'b1;
            ctrl.excode = inst_reg.excode;
        end else if (is_syscall) begin
            ctrl.ex     = 1'b1;
            ctrl.excode = EXC_SYS;
        end else if (!legal) begin
            ctrl.ex     = 1'b1;
            ctrl.excode = EXC_RI;
        end

        if (ctrl.ex) begin
            ctrl.gr_we  = 1'b0;
            ctrl.mem_we = 1'b0;
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module regfile import decode_pkg::*; (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  ws_to_rf_t              wr,
    output logic [`DATA_W-1:0]     rdata1,
    output logic [`DATA_W-1:0]     rdata2
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired, never stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* operand_bypass.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module operand_bypass import decode_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    input  logic [`DATA_W-1:0]     rf_rs,
    input  logic [`DATA_W-1:0]     rf_rt,
    input  fwd_t                   es_fwd,
    input  fwd_t                   ms_fwd,
    input  ws_to_rf_t              ws_rf,
    output logic [`DATA_W-1:0]     rs_value,
    output logic [`DATA_W-1:0]     rt_value
);

    // youngest producer wins
    function automatic logic [`DATA_W-1:0] pick(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`DATA_W-1:0]     rf_val,
        input fwd_t                   es,
        input fwd_t                   ms,
        input ws_to_rf_t              ws
    );
        if (addr == '0) begin
            return '0;
        end else if (es.gr_we && !es.is_load && es.dest == addr) begin
            return es.result;  // load data not there yet, stall covers it
        end else if (ms.gr_we && ms.dest == addr) begin
            return ms.result;
        end else if (ws.we && ws.addr == addr) begin
            return ws.data;  // same-cycle write
        end
        return rf_val;
    endfunction

    assign rs_value = pick(rs_addr, rf_rs, es_fwd, ms_fwd, ws_rf);
    assign rt_value = pick(rt_addr, rf_rt, es_fwd, ms_fwd, ws_rf);

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module branch_unit import decode_pkg::*; (
    input  br_kind_e           kind,
    input  logic [`DATA_W-1:0] pc,
    input  logic [15:0]        imm,
    input  logic [25:0]        jidx,
    input  logic [`DATA_W-1:0] rs_value,
    input  logic [`DATA_W-1:0] rt_value,
    input  logic               active,
    output br_bus_t            br
);

    logic [`DATA_W-1:0] pc_next;   // address after this instruction
    logic [`DATA_W-1:0] br_offset;
    logic               cond;
    logic [`DATA_W-1:0] target;

    assign pc_next   = pc + `DATA_W'(`PC_STEP);
    assign br_offset = {{(`DATA_W - 18){imm[15]}}, imm, 2'b00};

    always_comb begin
        cond   = 1'b0;
        target = pc_next;
        case (kind)
            BR_BEQ: begin
                cond   = (rs_value == rt_value);
                target = pc_next + br_offset;
            end
            BR_BNE: begin
                cond   = (rs_value != rt_value);
                target = pc_next + br_offset;
            end
            BR_J, BR_JAL: begin
                cond   = 1'b1;
                target = {pc_next[`DATA_W-1:`DATA_W-4], jidx, 2'b00};  // region of pc + 4
            end
            BR_JR: begin
                cond   = 1'b1;
                target = rs_value;
            end
            default: cond = 1'b0;
        endcase
    end

    // only announced in a cycle where the stage hands off
    assign br.taken  = active && cond;
    assign br.target = target;

    a_no_branch_no_redirect: assert final (!(br.taken && kind == BR_NONE))
        else $error("branch taken with kind NONE");

endmodule

/* id_stage.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module id_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_valid,
    input  fs_to_ds_t fs_bus,
    input  logic      es_allowin,
    input  fwd_t      es_fwd,
    input  fwd_t      ms_fwd,
    input  ws_to_rf_t ws_rf,
    output logic      ds_allowin,
    output logic      ds_valid_out,
    output ds_to_es_t ds_bus,
    output br_bus_t   br
);

    fs_to_ds_t              inst_reg;
    dec_ctrl_t              ctrl;
    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`DATA_W-1:0]     rf_rs;
    logic [`DATA_W-1:0]     rf_rt;
    logic [`DATA_W-1:0]     rs_value;
    logic [`DATA_W-1:0]     rt_value;

    assign rs_addr = inst_reg.inst[`RS_MSB:`RS_LSB];
    assign rt_addr = inst_reg.inst[`RT_MSB:`RT_LSB];

    id_pipe_ctrl u_ctrl (
        .clk, .reset, .fs_valid, .fs_bus, .es_allowin, .es_fwd,
        .rs_addr, .rt_addr,
        .uses_rs      (ctrl.uses_rs),
        .uses_rt      (ctrl.uses_rt),
        .ds_allowin, .ds_valid_out,
        .go           (),  // already folded into ds_valid_out
        .inst_reg
    );

    inst_decoder u_dec (.inst_reg, .ctrl);

    regfile u_rf (
        .clk, .raddr1 (rs_addr), .raddr2 (rt_addr), .wr (ws_rf),
        .rdata1 (rf_rs), .rdata2 (rf_rt)
    );

    operand_bypass u_byp (
        .rs_addr, .rt_addr, .rf_rs, .rf_rt, .es_fwd, .ms_fwd, .ws_rf,
        .rs_value, .rt_value
    );

    branch_unit u_br (
        .kind     (ctrl.br_kind),
        .pc       (inst_reg.pc),
        .imm      (ctrl.imm),
        .jidx     (inst_reg.inst[25:0]),
        .rs_value, .rt_value,
        .active   (ds_valid_out),
        .br
    );

    always_comb begin
        ds_bus.ex       = ctrl.ex;
        ds_bus.excode   = ctrl.excode;
        ds_bus.alu_op   = ctrl.alu_op;
        ds_bus.src1_sel = ctrl.src1_sel;
        ds_bus.src2_sel = ctrl.src2_sel;
        ds_bus.gr_we    = ctrl.gr_we;
        ds_bus.mem_we   = ctrl.mem_we;
        ds_bus.is_load  = ctrl.is_load;
        ds_bus.dest     = ctrl.dest;
        ds_bus.imm      = ctrl.imm;
        ds_bus.rs_value = rs_value;
        ds_bus.rt_value = rt_value;  // store data for sw
        ds_bus.pc       = inst_reg.pc;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* tb_id_stage.sv */
`timescale 1ns/1ps
`include "decode_settings.svh"

module tb_id_stage import decode_pkg::*; ();

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        excode_e     fexc;      // fault coming in from fetch
        fwd_t        es;
        fwd_t        es_after;  // execute source once the stall ends
        fwd_t        ms;
        ws_to_rf_t   ws;
        int          stall;
        int          bp;        // cycles of es_allowin low
        alu_op_e     alu;
        src1_sel_e   s1;
        src2_sel_e   s2;
        logic        gr_we;
        logic        mem_we;
        logic        is_load;
        logic [4:0]  dest;
        excode_e     exc;
        br_kind_e    kind;
    } entry_t;

    logic      clk;
    logic      reset;
    logic      fs_valid;
    fs_to_ds_t fs_bus;
    logic      es_allowin;
    fwd_t      es_fwd;
    fwd_t      ms_fwd;
    ws_to_rf_t ws_rf;
    logic      ds_allowin;
    logic      ds_valid_out;
    ds_to_es_t ds_bus;
    br_bus_t   br;

    entry_t      tbl[$];
    logic [31:0] model [32];
    int          cycles = 0;
    int          limit = 0;
    int          errors = 0;

    tb_clock_gen clk_gen (.clk, .reset);

    id_stage dut0 (
        .clk, .reset, .fs_valid, .fs_bus, .es_allowin, .es_fwd, .ms_fwd, .ws_rf,
        .ds_allowin, .ds_valid_out, .ds_bus, .br
    );

    function automatic logic [31:0] rtype(int rs, int rt, int rd, int sa, int fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] itype(int op, int rs, int rt, int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jtype(int op, int idx);
        return {op[5:0], idx[25:0]};
    endfunction

    // execute, then memory, then writeback, then the register model
    function automatic logic [31:0] exp_operand(logic [4:0] a, fwd_t es, fwd_t ms, ws_to_rf_t ws);
        if (a == 5'd0) return 32'd0;
        if (es.gr_we && !es.is_load && es.dest == a) return es.result;
        if (ms.gr_we && ms.dest == a) return ms.result;
        if (ws.we && ws.addr == a) return ws.data;
        return model[a];
    endfunction

    function automatic logic [31:0] exp_target(br_kind_e k, logic [31:0] pc, logic [31:0] inst,
                                               logic [31:0] rsv);
        logic [31:0] pn;
        pn = pc + 32'd4;
        if (k == BR_J || k == BR_JAL) return {pn[31:28], inst[25:0], 2'b00};
        if (k == BR_JR) return rsv;
        return pn + {{14{inst[15]}}, inst[15:0], 2'b00};
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic add(logic [31:0] inst, alu_op_e alu, src1_sel_e s1, src2_sel_e s2,
                       logic gr, logic mem, logic ld, int dest, excode_e exc, br_kind_e kind);
        entry_t e;
        e = '{inst: inst, pc: 32'h0040_0100 + 32'(tbl.size() * 4), fexc: EXC_NONE,
              es: '0, es_after: '0, ms: '0, ws: '0, stall: 0, bp: 0, alu: alu, s1: s1,
              s2: s2, gr_we: gr, mem_we: mem, is_load: ld, dest: dest[4:0], exc: exc,
              kind: kind};
        tbl.push_back(e);
    endtask

    task automatic build_table();
        int n;
        add(rtype(1, 2, 3, 0, FN_ADDU), ALU_ADD, SRC1_RS, SRC2_RT, 1, 0, 0, 3, EXC_NONE, BR_NONE);
        add(rtype(4, 5, 6, 0, FN_SUBU), ALU_SUB, SRC1_RS, SRC2_RT, 1, 0, 0, 6, EXC_NONE, BR_NONE);
        add(rtype(7, 8, 9, 0, FN_SLT), ALU_SLT, SRC1_RS, SRC2_RT, 1, 0, 0, 9, EXC_NONE, BR_NONE);
        add(rtype(10, 11, 12, 0, FN_SLTU), ALU_SLTU, SRC1_RS, SRC2_RT, 1, 0, 0, 12, EXC_NONE,
            BR_NONE);
        add(rtype(13, 14, 15, 0, FN_AND), ALU_AND, SRC1_RS, SRC2_RT, 1, 0, 0, 15, EXC_NONE, BR_NONE);
        add(rtype(16, 17, 18, 0, FN_OR), ALU_OR, SRC1_RS, SRC2_RT, 1, 0, 0, 18, EXC_NONE, BR_NONE);
        add(rtype(19, 20, 21, 0, FN_XOR), ALU_XOR, SRC1_RS, SRC2_RT, 1, 0, 0, 21, EXC_NONE, BR_NONE);
        add(rtype(22, 23, 24, 0, FN_NOR), ALU_NOR, SRC1_RS, SRC2_RT, 1, 0, 0, 24, EXC_NONE, BR_NONE);
        add(rtype(0, 7, 4, 5, FN_SLL), ALU_SLL, SRC1_SA, SRC2_RT, 1, 0, 0, 4, EXC_NONE, BR_NONE);
        add(rtype(0, 8, 5, 31, FN_SRL), ALU_SRL, SRC1_SA, SRC2_RT, 1, 0, 0, 5, EXC_NONE, BR_NONE);
        add(itype(OP_ADDIU, 9, 8, 'h8001), ALU_ADD, SRC1_RS, SRC2_SIMM, 1, 0, 0, 8, EXC_NONE,
            BR_NONE);
        add(itype(OP_ANDI, 10, 11, 'hf0f0), ALU_AND, SRC1_RS, SRC2_ZIMM, 1, 0, 0, 11, EXC_NONE,
            BR_NONE);
        add(itype(OP_ORI, 12, 13, 'h8421), ALU_OR, SRC1_RS, SRC2_ZIMM, 1, 0, 0, 13, EXC_NONE,
            BR_NONE);
        add(itype(OP_LUI, 0, 10, 'h1234), ALU_LUI, SRC1_RS, SRC2_SIMM, 1, 0, 0, 10, EXC_NONE,
            BR_NONE);
        add(itype(OP_LW, 12, 11, 'h0010), ALU_ADD, SRC1_RS, SRC2_SIMM, 1, 0, 1, 11, EXC_NONE,
            BR_NONE);
        add(itype(OP_SW, 14, 13, 'hfffc), ALU_ADD, SRC1_RS, SRC2_SIMM, 0, 1, 0, 0, EXC_NONE,
            BR_NONE);
        // forwarding sources withdrawn one by one
        for (int k = 0; k < 4; k++) begin
            add(rtype(k == 3 ? 0 : 5, 6, 3, 0, FN_ADDU), ALU_ADD, SRC1_RS, SRC2_RT, 1, 0, 0, 3,
                EXC_NONE, BR_NONE);
            n = tbl.size() - 1;
            if (k == 0 || k == 3) tbl[n].es = fwd_t'{1'b1, 1'b0, k == 3 ? 5'd0 : 5'd5, 32'he5e5_0001};
            if (k <= 1 || k == 3) tbl[n].ms = fwd_t'{1'b1, 1'b0, k == 3 ? 5'd0 : 5'd5, 32'h3535_0002};
            if (k <= 2) tbl[n].ws = ws_to_rf_t'{1'b1, 5'd5, 32'h4545_0003 + 32'(k)};
        end
        // load in execute feeding rs, then rt
        add(rtype(5, 6, 3, 0, FN_ADDU), ALU_ADD, SRC1_RS, SRC2_RT, 1, 0, 0, 3, EXC_NONE, BR_NONE);
        n = tbl.size() - 1;
        tbl[n].es    = fwd_t'{1'b1, 1'b1, 5'd5, 32'hbad0_0005};
        tbl[n].ms    = fwd_t'{1'b1, 1'b0, 5'd5, 32'h1d1d_0005};
        tbl[n].stall = 3;
        add(rtype(6, 7, 3, 0, FN_SUBU), ALU_SUB, SRC1_RS, SRC2_RT, 1, 0, 0, 3, EXC_NONE, BR_NONE);
        n = tbl.size() - 1;
        tbl[n].es    = fwd_t'{1'b1, 1'b1, 5'd7, 32'hbad0_0007};
        tbl[n].ms    = fwd_t'{1'b1, 1'b0, 5'd7, 32'h1d1d_0007};
        tbl[n].stall = 2;
        add(itype(OP_BEQ, 1, 1, 'h0003), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_NONE, BR_BEQ);
        add(itype(OP_BEQ, 1, 2, 'hfffe), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_NONE, BR_BEQ);
        add(itype(OP_BNE, 1, 2, 'hfff0), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_NONE, BR_BNE);
        add(itype(OP_BNE, 2, 2, 'h0010), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_NONE, BR_BNE);
        add(jtype(OP_J, 'h0abcdef), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_NONE, BR_J);
        tbl[tbl.size() - 1].pc = 32'h2fff_fffc;  // pc + 4 crosses into the next region
        add(jtype(OP_JAL, 'h1234567), ALU_ADD, SRC1_PC, SRC2_EIGHT, 1, 0, 0, 31, EXC_NONE, BR_JAL);
        add(rtype(9, 0, 0, 0, FN_JR), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_NONE, BR_JR);
        add(itype('h3f, 1, 2, 'h0004), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_RI, BR_NONE);
        add({6'h00, 20'h12345, 6'h0c}, ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_SYS, BR_NONE);
        add(rtype(1, 2, 3, 0, FN_ADDU), ALU_ADD, SRC1_RS, SRC2_RT, 0, 0, 0, 0, EXC_ADEL, BR_NONE);
        tbl[tbl.size() - 1].fexc = EXC_ADEL;
        add(rtype(1, 2, 3, 0, FN_ADDU), ALU_ADD, SRC1_RS, SRC2_RT, 1, 0, 0, 3, EXC_NONE, BR_NONE);
        tbl[tbl.size() - 1].bp = 3;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: DUT did not finish within %0d cycles", limit);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial begin
        int          seed;
        entry_t      e;
        fwd_t        es_eff;
        ds_to_es_t   held;
        logic [31:0] rsv;
        logic [31:0] rtv;
        logic        tk;
        fs_valid   = 1'b0;
        fs_bus     = '0;
        es_allowin = 1'b1;
        es_fwd     = '0;
        ms_fwd     = '0;
        ws_rf      = '0;
        seed = $urandom(32'h97f9);
        build_table();
        limit = tbl.size() * 10 + 50;
        wait (!reset);
        @(negedge clk);
        check("ds_valid_out", 32'(ds_valid_out), 32'd0);
        check("br.taken", 32'(br.taken), 32'd0);
        check("ds_allowin", 32'(ds_allowin), 32'd1);

        model[0] = 32'd0;
        for (int i = 1; i < 32; i++) begin  // preload through the writeback port
            model[i] = $urandom();
            ws_rf = ws_to_rf_t'{1'b1, 5'(i), model[i]};
            @(negedge clk);
        end
        ws_rf = '0;

        foreach (tbl[n]) begin
            e = tbl[n];
            es_eff = (e.stall > 0) ? e.es_after : e.es;
            check("ds_allowin", 32'(ds_allowin), 32'd1);
            fs_valid      = 1'b1;
            fs_bus.ex     = (e.fexc != EXC_NONE);
            fs_bus.excode = e.fexc;
            fs_bus.inst   = e.inst;
            fs_bus.pc     = e.pc;
            es_fwd        = e.es;
            ms_fwd        = e.ms;
            es_allowin    = (e.bp == 0);
            @(negedge clk);
            fs_valid = 1'b0;
            ws_rf    = e.ws;  // write lands while the operand is read
            for (int s = 0; s < e.stall; s++) begin
                check("ds_valid_out", 32'(ds_valid_out), 32'd0);
                check("ds_allowin", 32'(ds_allowin), 32'd0);
                @(negedge clk);
            end
            es_fwd = es_eff;
            #1;
            while (!ds_valid_out) @(negedge clk);

            rsv = exp_operand(e.inst[25:21], es_eff, e.ms, e.ws);
            rtv = exp_operand(e.inst[20:16], es_eff, e.ms, e.ws);
            tk  = (e.kind == BR_BEQ) ? (rsv == rtv) : (e.kind == BR_BNE) ? (rsv != rtv) :
                  (e.kind == BR_J || e.kind == BR_JAL || e.kind == BR_JR);
            check("ex", 32'(ds_bus.ex), 32'(e.exc != EXC_NONE));
            check("excode", 32'(ds_bus.excode), 32'(e.exc));
            check("gr_we", 32'(ds_bus.gr_we), 32'(e.gr_we));
            check("mem_we", 32'(ds_bus.mem_we), 32'(e.mem_we));
            if (e.gr_we) check("dest", 32'(ds_bus.dest), 32'(e.dest));
            if (e.gr_we || e.mem_we) begin
                check("alu_op", 32'(ds_bus.alu_op), 32'(e.alu));
                check("src1_sel", 32'(ds_bus.src1_sel), 32'(e.s1));
                check("src2_sel", 32'(ds_bus.src2_sel), 32'(e.s2));
                check("is_load", 32'(ds_bus.is_load), 32'(e.is_load));
            end
            check("imm", 32'(ds_bus.imm), 32'(e.inst[15:0]));
            check("rs_value", ds_bus.rs_value, rsv);
            check("rt_value", ds_bus.rt_value, rtv);
            check("pc", ds_bus.pc, e.pc);
            check("br.taken", 32'(br.taken), 32'(tk));
            if (tk) check("br.target", br.target, exp_target(e.kind, e.pc, e.inst, rsv));

            held = ds_bus;
            for (int b = 0; b < e.bp; b++) begin
                check("ds_allowin", 32'(ds_allowin), 32'd0);
                @(negedge clk);
                check("ds_bus held", 32'(ds_bus == held), 32'd1);
            end
            if (e.ws.we && e.ws.addr != 5'd0) model[e.ws.addr] = e.ws.data;
            es_allowin = 1'b1;  // let it leave, then drain
            @(negedge clk);
            es_fwd = '0;
            ms_fwd = '0;
            ws_rf  = '0;
        end

        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
decode_pkg.sv
id_pipe_ctrl.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_clock_gen.sv
tb_id_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_id_stage -o sim_id_stage
out=$(./obj_dir/sim_id_stage) || true
echo "$out"
echo "$out" | grep -q "All checks passed"
